/* hw/link_pkg.sv */
// link packet formats
package link_pkg;

  // fixed widths of the link format
  localparam int data_width_lp = 32;
  localparam int addr_width_lp = 10;
  localparam int cord_width_lp = 4;

  // data word carried by both packet types
  typedef logic [data_width_lp-1:0] data_t;

  // word address into the endpoint memory
  typedef logic [addr_width_lp-1:0] addr_t;

  // x or y position of a tile
  typedef logic [cord_width_lp-1:0] cord_t;

  // request on the forward link, 52 bits
  typedef struct packed {
    logic [1:0] op;
    addr_t      addr;
    data_t      data;
    cord_t      src_x;
    cord_t      src_y;
  } fwd_pkt_s;

  // response on the return link, 42 bits
  typedef struct packed {
    logic [1:0] kind;
    data_t      data;
    cord_t      dest_x;
    cord_t      dest_y;
  } rev_pkt_s;

endpackage

/* hw/endpoint_pkg.sv */
// endpoint request and result types
package endpoint_pkg;

  import link_pkg::*;

  typedef enum logic [1:0] {
    op_load   = 2'd0,
    op_store  = 2'd1,
    op_amoadd = 2'd2
  } op_e;

  typedef enum logic [1:0] {
    rev_load  = 2'd0,
    rev_store = 2'd1,
    rev_amo   = 2'd2,
    rev_error = 2'd3
  } rev_kind_e;

  // phase of the execute stage
  typedef enum logic [1:0] {
    exec_idle,
    exec_read,
    exec_write
  } exec_state_e;

  // classified request handed to the execute stage
  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t data;
    cord_t src_x;
    cord_t src_y;
    logic  in_range;
  } exec_req_s;

  typedef struct packed {
    rev_kind_e kind;
    data_t     data;
    cord_t     dest_x;
    cord_t     dest_y;
  } exec_res_s;

endpackage

/* hw/req_decode.sv */
// forward request decode
`timescale 1ns/1ps

module req_decode
  import link_pkg::*, endpoint_pkg::*;
 #(parameter int mem_els_p = 256
  )
  (input  logic      clk_i
  ,input  logic      rst_i
  ,input  logic      fwd_v_i
  ,input  fwd_pkt_s  fwd_pkt_i
  ,output logic      fwd_ready_o
  ,output logic      dec_v_o
  ,output exec_req_s dec_req_o
  ,input  logic      exe_ready_i
  );

  logic      dec_v_r;
  exec_req_s dec_req_r;
  exec_req_s dec_req_n;
  logic      op_known;
  logic      addr_ok;

  // room when empty or when the held request leaves this cycle
  assign fwd_ready_o = ~dec_v_r | exe_ready_i;

  always_comb
  begin
    op_known = (fwd_pkt_i.op == op_load) | (fwd_pkt_i.op == op_store)
             | (fwd_pkt_i.op == op_amoadd);
    addr_ok = 32'(fwd_pkt_i.addr) < mem_els_p;
    dec_req_n.op = op_e'(fwd_pkt_i.op);
    dec_req_n.addr = fwd_pkt_i.addr;
    dec_req_n.data = fwd_pkt_i.data;
    dec_req_n.src_x = fwd_pkt_i.src_x;
    dec_req_n.src_y = fwd_pkt_i.src_y;
    // an unknown op is answered like a bad address
    dec_req_n.in_range = op_known & addr_ok;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      dec_v_r <= 1'b0;
    else if (fwd_ready_o)
      dec_v_r <= fwd_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_v_i & fwd_ready_o)
      dec_req_r <= dec_req_n;
  end

  assign dec_v_o   = dec_v_r;
  assign dec_req_o = dec_req_r;

endmodule

/* hw/mem_execute.sv */
// local memory execute stage
`timescale 1ns/1ps

module mem_execute
  import link_pkg::*, endpoint_pkg::*;
 #(parameter int mem_els_p = 256
  )
  (input  logic      clk_i
  ,input  logic      rst_i
  ,input  logic      dec_v_i
  ,input  exec_req_s dec_req_i
  ,output logic      exe_ready_o
  ,output logic      exe_v_o
  ,output exec_res_s exe_res_o
  ,input  logic      res_ready_i
  );

  localparam int idx_width_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1;

  data_t                   mem_r [mem_els_p];
  exec_state_e             state_r;
  exec_state_e             phase;
  exec_req_s               req_r;
  data_t                   old_r;
  logic                    exe_v_r;
  exec_res_s               res_r;
  exec_res_s               res_n;
  logic                    accept;
  logic                    amo_hit;
  logic [idx_width_lp-1:0] rd_idx;
  data_t                   rd_data;
  logic                    mem_we;
  logic [idx_width_lp-1:0] wr_idx;
  data_t                   wr_data;

  // take a new request only when the result register is free or draining
  assign exe_ready_o = (state_r == exec_idle) & (~exe_v_r | res_ready_i);
  assign accept      = dec_v_i & exe_ready_o;
  assign amo_hit     = dec_req_i.in_range & (dec_req_i.op == op_amoadd);
  assign rd_idx      = dec_req_i.addr[idx_width_lp-1:0];
  assign rd_data     = mem_r[rd_idx];

  // the accept cycle of an atomic add is its read phase
  always_comb
  begin
    if (state_r == exec_write)
      phase = exec_write;
    else if (accept & amo_hit)
      phase = exec_read;
    else
      phase = exec_idle;
  end

  // single-cycle results
  always_comb
  begin
    res_n.dest_x = dec_req_i.src_x;
    res_n.dest_y = dec_req_i.src_y;
    res_n.kind = rev_error;
    res_n.data = '0;
    if (dec_req_i.in_range)
    begin
      case (dec_req_i.op)
        op_load:
        begin
          res_n.kind = rev_load;
          res_n.data = rd_data;
        end
        op_store:
          res_n.kind = rev_store;
        default:
          res_n.kind = rev_error;
      endcase
    end
  end

  assign mem_we = (phase == exec_write)
                | ((phase == exec_idle) & accept & dec_req_i.in_range
                   & (dec_req_i.op == op_store));
  assign wr_idx  = (phase == exec_write) ? req_r.addr[idx_width_lp-1:0] : rd_idx;
  assign wr_data = (phase == exec_write) ? old_r + req_r.data : dec_req_i.data;

  always_ff @(posedge clk_i)
  begin
    if (mem_we)
      mem_r[wr_idx] <= wr_data;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= exec_idle;
      exe_v_r <= 1'b0;
    end
    else
    begin
      if (res_ready_i)
        exe_v_r <= 1'b0;
      case (phase)
        exec_idle:
          if (accept)
            exe_v_r <= 1'b1;
        exec_read:
          state_r <= exec_write;
        default:
        begin
          state_r <= exec_idle;
          exe_v_r <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    case (phase)
      exec_idle:
        if (accept)
          res_r <= res_n;
      exec_read:
      begin
        req_r <= dec_req_i;
        old_r <= rd_data;
      end
      default:
      begin
        // atomic add answers with the value before the update
        res_r.kind <= rev_amo;
        res_r.data <= old_r;
        res_r.dest_x <= req_r.src_x;
        res_r.dest_y <= req_r.src_y;
      end
    endcase
  end

  assign exe_v_o   = exe_v_r;
  assign exe_res_o = res_r;

endmodule

/* hw/resp_credit_out.sv */
// credit-based response sender
`timescale 1ns/1ps

module resp_credit_out
  import link_pkg::*, endpoint_pkg::*;
 #(parameter int fifo_els_p = 3
  )
  (input  logic      clk_i
  ,input  logic      rst_i
  ,input  logic      exe_v_i
  ,input  exec_res_s exe_res_i
  ,output logic      res_ready_o
  ,output logic      crd_v_o
  ,output rev_pkt_s  crd_pkt_o
  ,input  logic      crd_return_i
  );

  localparam int credit_width_lp = $clog2(fifo_els_p + 1);

  logic [credit_width_lp-1:0] credits_r;
  logic                       crd_v_r;
  rev_pkt_s                   crd_pkt_r;
  logic                       take;

  // a packet waiting to go out has already claimed one credit
  assign res_ready_o = credits_r > credit_width_lp'(crd_v_r);
  assign take        = exe_v_i & res_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      credits_r <= credit_width_lp'(fifo_els_p);
    else
    begin
      case ({crd_v_r, crd_return_i})
        2'b10:
          credits_r <= credits_r - 1'b1;
        2'b01:
          credits_r <= credits_r + 1'b1;
        default:
          credits_r <= credits_r;
      endcase
    end
  end

  // one-cycle send per accepted result
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      crd_v_r <= 1'b0;
    else
      crd_v_r <= take;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      crd_pkt_r.kind <= exe_res_i.kind;
      crd_pkt_r.data <= exe_res_i.data;
      crd_pkt_r.dest_x <= exe_res_i.dest_x;
      crd_pkt_r.dest_y <= exe_res_i.dest_y;
    end
  end

  assign crd_v_o   = crd_v_r;
  assign crd_pkt_o = crd_pkt_r;

endmodule

/* hw/resp_fifo.sv */
// return packet FIFO
`timescale 1ns/1ps

module resp_fifo
  import link_pkg::*;
 #(parameter int els_p = 3
  )
  (input  logic     clk_i
  ,input  logic     rst_i
  ,input  logic     v_i
  ,input  rev_pkt_s data_i
  ,output logic     ready_o
  ,output logic     v_o
  ,output rev_pkt_s data_o
  ,input  logic     yumi_i
  );

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  rev_pkt_s                mem_r [els_p];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    enq;
  logic                    deq;

  assign ready_o = count_r != cnt_width_lp'(els_p);
  assign v_o     = count_r != '0;
  assign data_o  = mem_r[rptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i & v_o;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

  // pointers wrap at els_p, which need not be a power of two
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end
    else
    begin
      if (enq)
        wptr_r <= (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      if (deq)
        rptr_r <= (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      case ({enq, deq})
        2'b10:
          count_r <= count_r + 1'b1;
        2'b01:
          count_r <= count_r - 1'b1;
        default:
          count_r <= count_r;
      endcase
    end
  end

endmodule

/* hw/resp_credit_to_ready_and.sv */
// credit to valid/ready response adapter
`timescale 1ns/1ps

module resp_credit_to_ready_and
  import link_pkg::*;
 #(parameter int fifo_els_p = 3
  )
  (input  logic     clk_i
  ,input  logic     rst_i
  ,input  logic     crd_v_i
  ,input  rev_pkt_s crd_pkt_i
  ,output logic     crd_return_o
  ,output logic     rev_v_o
  ,output rev_pkt_s rev_pkt_o
  ,input  logic     rev_ready_i
  );

  logic fifo_yumi;
  logic crd_return_r;

  assign fifo_yumi = rev_v_o & rev_ready_i;

  // sender only transmits under credit, so the FIFO always has room
  resp_fifo
 #(.els_p  (fifo_els_p)
  ) sink_fifo
  (.clk_i  (clk_i     )
  ,.rst_i  (rst_i     )
  ,.v_i    (crd_v_i   )
  ,.data_i (crd_pkt_i )
  ,.ready_o(          )
  ,.v_o    (rev_v_o   )
  ,.data_o (rev_pkt_o )
  ,.yumi_i (fifo_yumi )
  );

  // credit goes back one cycle after each dequeue
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      crd_return_r <= 1'b0;
    else
      crd_return_r <= fifo_yumi;
  end

  assign crd_return_o = crd_return_r;

endmodule

/* hw/link_endpoint_top.sv */
// link endpoint top level
`timescale 1ns/1ps

module link_endpoint_top
  import link_pkg::*, endpoint_pkg::*;
 #(parameter int mem_els_p  = 256
  ,parameter int fifo_els_p = 3
  )
  (input  logic     clk_i
  ,input  logic     rst_i
  ,input  logic     fwd_v_i
  ,input  fwd_pkt_s fwd_pkt_i
  ,output logic     fwd_ready_o
  ,output logic     rev_v_o
  ,output rev_pkt_s rev_pkt_o
  ,input  logic     rev_ready_i
  );

  logic      dec_v;
  exec_req_s dec_req;
  logic      exe_ready;
  logic      exe_v;
  exec_res_s exe_res;
  logic      res_ready;
  logic      crd_v;
  rev_pkt_s  crd_pkt;
  logic      crd_return;

  req_decode
 #(.mem_els_p  (mem_els_p  )
  ) decode
  (.clk_i      (clk_i      )
  ,.rst_i      (rst_i      )
  ,.fwd_v_i    (fwd_v_i    )
  ,.fwd_pkt_i  (fwd_pkt_i  )
  ,.fwd_ready_o(fwd_ready_o)
  ,.dec_v_o    (dec_v      )
  ,.dec_req_o  (dec_req    )
  ,.exe_ready_i(exe_ready  )
  );

  mem_execute
 #(.mem_els_p  (mem_els_p  )
  ) execute
  (.clk_i      (clk_i      )
  ,.rst_i      (rst_i      )
  ,.dec_v_i    (dec_v      )
  ,.dec_req_i  (dec_req    )
  ,.exe_ready_o(exe_ready  )
  ,.exe_v_o    (exe_v      )
  ,.exe_res_o  (exe_res    )
  ,.res_ready_i(res_ready  )
  );

  resp_credit_out
 #(.fifo_els_p  (fifo_els_p)
  ) credit_out
  (.clk_i       (clk_i     )
  ,.rst_i       (rst_i     )
  ,.exe_v_i     (exe_v     )
  ,.exe_res_i   (exe_res   )
  ,.res_ready_o (res_ready )
  ,.crd_v_o     (crd_v     )
  ,.crd_pkt_o   (crd_pkt   )
  ,.crd_return_i(crd_return)
  );

  resp_credit_to_ready_and
 #(.fifo_els_p  (fifo_els_p )
  ) adapter
  (.clk_i       (clk_i      )
  ,.rst_i       (rst_i      )
  ,.crd_v_i     (crd_v      )
  ,.crd_pkt_i   (crd_pkt    )
  ,.crd_return_o(crd_return )
  ,.rev_v_o     (rev_v_o    )
  ,.rev_pkt_o   (rev_pkt_o  )
  ,.rev_ready_i (rev_ready_i)
  );

endmodule

/* dv/link_endpoint_tb.sv */
// link endpoint testbench
`timescale 1ns/1ps

module link_endpoint_tb
  import link_pkg::*, endpoint_pkg::*;
  ();

  localparam int mem_els_lp     = 256;
  localparam int fifo_els_lp    = 3;
  localparam int idx_width_lp   = $clog2(mem_els_lp);
  localparam int clk_period_lp  = 40;
  localparam int random_reqs_lp = 200;
  // 20 cycles for each preload store, directed case and random request
  localparam int req_budget_lp  = mem_els_lp + 40 + random_reqs_lp;
  localparam int watchdog_ns_lp = (req_budget_lp * 20 + 500) * clk_period_lp;

  typedef enum {ready_high, ready_low, ready_random} ready_mode_e;

  logic     clk_i;
  logic     rst_i;
  logic     fwd_v_i;
  fwd_pkt_s fwd_pkt_i;
  logic     fwd_ready_o;
  logic     rev_v_o;
  rev_pkt_s rev_pkt_o;
  logic     rev_ready_i;

  fwd_pkt_s    fwd_q [$];
  rev_pkt_s    exp_q [$];
  data_t       ref_mem [mem_els_lp];
  ready_mode_e ready_mode;
  integer      seed;
  integer      ready_seed;
  int          resp_count;
  int          fifo_level;

  link_endpoint_top
 #(.mem_els_p  (mem_els_lp )
  ,.fifo_els_p (fifo_els_lp)
  ) UUT
  (.clk_i      (clk_i      )
  ,.rst_i      (rst_i      )
  ,.fwd_v_i    (fwd_v_i    )
  ,.fwd_pkt_i  (fwd_pkt_i  )
  ,.fwd_ready_o(fwd_ready_o)
  ,.rev_v_o    (rev_v_o    )
  ,.rev_pkt_o  (rev_pkt_o  )
  ,.rev_ready_i(rev_ready_i)
  );

  initial
    clk_i = 1'b0;

  always
    #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  // every address bit changes the pattern
  function automatic data_t fill_word(input addr_t addr);
    return (data_t'(addr) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  // queue one request and predict its response from the reference memory
  task automatic add_req(input logic [1:0] op, input addr_t addr, input data_t data);
    fwd_pkt_s    pkt;
    rev_pkt_s    want;
    logic [31:0] rnd;
    logic        in_range;
    rnd = $random(seed);
    pkt.op = op;
    pkt.addr = addr;
    pkt.data = data;
    pkt.src_x = rnd[3:0];
    pkt.src_y = rnd[7:4];
    in_range = (int'(addr) < mem_els_lp) && (op != 2'd3);
    want.dest_x = pkt.src_x;
    want.dest_y = pkt.src_y;
    want.kind = rev_error;
    want.data = '0;
    if (in_range)
    begin
      case (op)
        op_load:
        begin
          want.kind = rev_load;
          want.data = ref_mem[addr[idx_width_lp-1:0]];
        end
        op_store:
        begin
          want.kind = rev_store;
          ref_mem[addr[idx_width_lp-1:0]] = data;
        end
        default:
        begin
          want.kind = rev_amo;
          want.data = ref_mem[addr[idx_width_lp-1:0]];
          ref_mem[addr[idx_width_lp-1:0]] = want.data + data;
        end
      endcase
    end
    fwd_q.push_back(pkt);
    exp_q.push_back(want);
  endtask

  task automatic wait_idle;
    while (fwd_q.size() != 0 || exp_q.size() != 0)
      @(posedge clk_i);
  endtask

  // forward link sender
  always @(negedge clk_i)
  begin
    if (!rst_i && fwd_q.size() != 0)
    begin
      fwd_v_i = 1'b1;
      fwd_pkt_i = fwd_q[0];
      if (fwd_ready_o)
        fwd_q.delete(0);
    end
    else
      fwd_v_i = 1'b0;
  end

  // return link drive and response check
  always @(negedge clk_i)
  begin
    logic [31:0] rnd;
    rev_pkt_s    want;
    logic        take;
    rnd = $random(ready_seed);
    case (ready_mode)
      ready_low:
        rev_ready_i = 1'b0;
      ready_random:
        rev_ready_i = rnd[0];
      default:
        rev_ready_i = 1'b1;
    endcase
    take = rev_v_o & rev_ready_i;
    if (!rst_i)
    begin
      // an enqueue needs a free slot even when a dequeue happens alongside
      if (UUT.crd_v)
        assert (fifo_level < fifo_els_lp)
        else
          abort_run("the response FIFO was written while already full");
      fifo_level = fifo_level + int'(UUT.crd_v) - int'(take);
      if (take)
      begin
        if (exp_q.size() == 0)
          abort_run("a response arrived that no request asked for");
        else
        begin
          want = exp_q.pop_front();
          assert (rev_pkt_o == want)
          else
            abort_run({
              $sformatf("FAILED at %0d ns: response %0d expected kind %0d data %h",
                $time, resp_count, want.kind, want.data),
              $sformatf(" dest (%0d,%0d), got kind %0d data %h dest (%0d,%0d)",
                want.dest_x, want.dest_y, rev_pkt_o.kind, rev_pkt_o.data,
                rev_pkt_o.dest_x, rev_pkt_o.dest_y)});
          resp_count++;
        end
      end
    end
  end

  initial
  begin
    #(watchdog_ns_lp);
    abort_run("timeout: the responses did not all arrive in time");
  end

  initial
  begin
    logic [31:0] rnd;
    logic [1:0]  op;
    addr_t       addr;
    seed = 32'h71f9_e345;
    ready_seed = 32'h71f9_e345;
    resp_count = 0;
    fifo_level = 0;
    ready_mode = ready_high;
    rst_i = 1'b1;
    fwd_v_i = 1'b0;
    fwd_pkt_i = '0;
    rev_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    assert (fwd_ready_o && !rev_v_o && UUT.credit_out.credits_r == fifo_els_lp)
    else
      abort_run("ready, valid or credit count is wrong after reset");
    @(posedge clk_i);

    // the memory has no reset, so give every word a known value
    for (int a = 0; a < mem_els_lp; a++)
      add_req(op_store, addr_t'(a), fill_word(addr_t'(a)));
    wait_idle();

    // store then load of the same word
    rnd = $random(seed);
    add_req(op_store, 10'd37, rnd);
    add_req(op_load, 10'd37, '0);
    wait_idle();

    // atomic add whose first operand wraps past 2**32
    add_req(op_amoadd, 10'd90, 32'hffff_fff0);
    add_req(op_load, 10'd90, '0);
    add_req(op_amoadd, 10'd90, 32'h0000_0123);
    add_req(op_load, 10'd90, '0);
    wait_idle();

    // bad addresses and an unknown op leave the aliased words alone
    add_req(op_store, 10'h2a5, 32'hdead_beef);
    add_req(op_amoadd, 10'h1a5, 32'h0000_0001);
    add_req(op_load, 10'h0a5, '0);
    add_req(2'd3, 10'h010, 32'h1234_5678);
    add_req(op_load, 10'h010, '0);
    wait_idle();

    // long back-pressure until the forward link stalls
    ready_mode = ready_low;
    for (int i = 0; i < 12; i++)
      add_req(op_load, addr_t'(i * 7), '0);
    @(negedge clk_i);
    while (fwd_ready_o)
      @(negedge clk_i);
    repeat (20) @(negedge clk_i);
    assert (fifo_level == fifo_els_lp && fwd_q.size() != 0)
    else
      abort_run("back-pressure did not fill the FIFO and hold the forward link");
    @(posedge clk_i);
    ready_mode = ready_high;
    wait_idle();

    // random mix under random return-link ready
    ready_mode = ready_random;
    for (int i = 0; i < random_reqs_lp; i++)
    begin
      rnd = $random(seed);
      addr = {2'b00, rnd[15:8]};
      case (rnd[2:0])
        3'd0, 3'd1:
          op = op_load;
        3'd2, 3'd3:
          op = op_store;
        3'd4, 3'd5:
          op = op_amoadd;
        3'd6:
          op = 2'd3;
        default:
        begin
          op = op_load;
          addr = {2'b11, rnd[15:8]};
        end
      endcase
      add_req(op, addr, $random(seed));
    end
    wait_idle();
    ready_mode = ready_high;
    repeat (4) @(posedge clk_i);

    if (fifo_level == 0 && !rev_v_o && fwd_ready_o)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      abort_run("the endpoint did not return to idle after the last response");
  end

endmodule

/* project.f */
hw/link_pkg.sv
hw/endpoint_pkg.sv
hw/req_decode.sv
hw/mem_execute.sv
hw/resp_credit_out.sv
hw/resp_fifo.sv
hw/resp_credit_to_ready_and.sv
hw/link_endpoint_top.sv
dv/link_endpoint_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the link endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module link_endpoint_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vlink_endpoint_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
